/* design/cachePkg.sv */
// ================================================
// cache geometry for the 4-way data cache
// addresses are 64 bits, lines are 64 bytes
// tag width follows from index and offset widths
// ================================================
package cachePkg;

	localparam int numWays = 4;
	// few sets so that eviction shows up early
	localparam int indexBits = 4;
	localparam int offsetBits = 6;
	localparam int wordsPerLine = 8;
	localparam int lineBits = 512;
	localparam int tagBits = 64 - indexBits - offsetBits;
	// dirty and valid on top of the tag
	localparam int mdataBits = tagBits + 2;

	typedef enum logic [1:0] {
		cmdNone,
		cmdRead,
		cmdWrite,
		cmdFlush
	} cacheCmd_t;

	// one metadata word, as stored and as fields
	typedef union packed {
		logic [mdataBits-1:0] raw;
		struct packed {
			logic dirty;
			logic valid;
			logic [tagBits-1:0] tag;
		} fields;
	} cacheMeta_u;

endpackage

/* design/memBusPkg.sv */
// ================================================
// beat-serial memory port geometry
// one line is one fixed burst of eight beats
// ================================================
package memBusPkg;

	localparam int beatBits = 64;
	localparam int beatsPerBurst = 8;
	// wide enough to count every beat of a burst
	localparam int beatCountBits = 3;

endpackage

/* design/blockSram.sv */
// ================================================
// single-port RAM, depth 2**indexBits
// read data is registered, one cycle after index
// a write returns the old word on the same edge
// contents have no reset
// ================================================
`timescale 1ns/1ps

module blockSram import cachePkg::*; #(
	parameter int wordBits = 64,
	parameter int numWords = 8
) (
	input logic clk,
	input logic [indexBits-1:0] index,
	output logic [wordBits*numWords-1:0] rdData,
	input logic [wordBits*numWords-1:0] wrData,
	input logic [numWords-1:0] wrEnable
);

	logic [wordBits*numWords-1:0] mem [2**indexBits];

	always_ff @(posedge clk) begin
		// each enabled lane is written on its own
		for (int i = 0; i < numWords; i++) begin
			if (wrEnable[i]) begin
				mem[index][i*wordBits +: wordBits] <= wrData[i*wordBits +: wordBits];
			end
		end
		rdData <= mem[index];
	end

endmodule

/* design/lineReader.sv */
// ================================================
// reads one line as a burst of eight beats
// rdAddr must be line aligned, held by the caller
// rdDone pulses in the cycle after the last ack
// ================================================
`timescale 1ns/1ps

module lineReader import memBusPkg::*; (
	input logic clk,
	input logic reset,
	input logic rdStart,
	input logic [63:0] rdAddr,
	output logic rdDone,
	output logic [beatBits*beatsPerBurst-1:0] rdLine,
	output logic beatReq,
	output logic [63:0] beatAddr,
	input logic beatAck,
	input logic [beatBits-1:0] beatData
);

	logic [beatCountBits-1:0] beatCount;
	logic lastBeat;

	assign lastBeat = beatCount == beatCountBits'(beatsPerBurst - 1);

	always_ff @(posedge clk) begin
		if (reset) begin
			beatReq <= 1'b0;
			rdDone <= 1'b0;
			beatCount <= '0;
		end else begin
			rdDone <= 1'b0;
			if (rdStart) begin
				beatReq <= 1'b1;
				beatCount <= '0;
			end else if (beatReq && beatAck) begin
				beatCount <= beatCount + 1'b1;
				// request drops right after the eighth beat
				if (lastBeat) begin
					beatReq <= 1'b0;
					rdDone <= 1'b1;
				end
			end
		end
	end

	// beat 0 lands in the lowest word of the line
	always_ff @(posedge clk) begin
		if (rdStart) begin
			beatAddr <= rdAddr;
		end
		if (beatReq && beatAck) begin
			rdLine[beatCount*beatBits +: beatBits] <= beatData;
		end
	end

endmodule

/* design/lineWriter.sv */
// ================================================
// writes one line to memory as eight beats
// line and address are latched on wrStart
// wrDone pulses in the cycle after the last ack
// ================================================
`timescale 1ns/1ps

module lineWriter import memBusPkg::*; (
	input logic clk,
	input logic reset,
	input logic wrStart,
	input logic [63:0] wrAddr,
	input logic [beatBits*beatsPerBurst-1:0] wrLine,
	output logic wrDone,
	output logic beatReq,
	output logic [63:0] beatAddr,
	output logic [beatBits-1:0] beatWData,
	input logic beatAck
);

	logic [beatBits*beatsPerBurst-1:0] lineReg;
	logic [beatCountBits-1:0] beatCount;
	logic lastBeat;

	assign lastBeat = beatCount == beatCountBits'(beatsPerBurst - 1);
	// current beat, lowest word first
	assign beatWData = lineReg[beatCount*beatBits +: beatBits];

	always_ff @(posedge clk) begin
		if (reset) begin
			beatReq <= 1'b0;
			wrDone <= 1'b0;
			beatCount <= '0;
		end else begin
			wrDone <= 1'b0;
			if (wrStart) begin
				beatReq <= 1'b1;
				beatCount <= '0;
			end else if (beatReq && beatAck) begin
				beatCount <= beatCount + 1'b1;
				if (lastBeat) begin
					beatReq <= 1'b0;
					wrDone <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wrStart) begin
			lineReg <= wrLine;
			beatAddr <= wrAddr;
		end
	end

endmodule

/* design/memPortArbiter.sv */
// ================================================
// shares the memory port between reader and writer
// the owner keeps the port until it drops its request
// the writer wins when both ask in the same cycle
// ================================================
`timescale 1ns/1ps

module memPortArbiter import memBusPkg::*; (
	input logic clk,
	input logic reset,
	input logic rdReq,
	input logic [63:0] rdAddr,
	output logic rdAck,
	input logic wrReq,
	input logic [63:0] wrAddr,
	input logic [beatBits-1:0] wrData,
	output logic wrAck,
	output logic memReq,
	output logic memWrite,
	output logic [63:0] memAddr,
	output logic [beatBits-1:0] memWData,
	input logic memAck
);

	logic locked;
	logic grantWr;
	logic selWr;

	// fresh choice only while no burst is in flight
	assign selWr = locked ? grantWr : wrReq;

	assign memReq = selWr ? wrReq : rdReq;
	assign memWrite = memReq && selWr;
	assign memAddr = selWr ? wrAddr : rdAddr;
	assign memWData = wrData;
	assign rdAck = memAck && !selWr && rdReq;
	assign wrAck = memAck && selWr && wrReq;

	always_ff @(posedge clk) begin
		if (reset) begin
			locked <= 1'b0;
			grantWr <= 1'b0;
		end else if (!locked && memReq) begin
			locked <= 1'b1;
			grantWr <= selWr;
		end else if (locked && !memReq) begin
			locked <= 1'b0;
		end
	end

endmodule

/* design/setAssocDCache.sv */
// ================================================
// 4-way write-back data cache, 16 sets of 64 bytes
// one request at a time, reqCmd held until respCyc
// metadata RAM has no reset, must power up cleared
// no byte masks, flush works on a single line
// ================================================
`timescale 1ns/1ps

module setAssocDCache import cachePkg::*, memBusPkg::*; (
	input logic clk,
	input logic reset,
	input cacheCmd_t reqCmd,
	input logic [63:0] addr,
	input logic [63:0] writeData,
	output logic respCyc,
	output logic [63:0] readData,
	output logic memReq,
	output logic memWrite,
	output logic [63:0] memAddr,
	output logic [beatBits-1:0] memWData,
	input logic memAck,
	input logic [beatBits-1:0] memRData
);

	// request address fields
	logic [tagBits-1:0] reqTag;
	logic [indexBits-1:0] index;
	logic [$clog2(wordsPerLine)-1:0] wordSel;
	logic [63:0] lineAddr;

	// per-way RAM ports
	logic [lineBits-1:0] lineRd [numWays];
	logic [lineBits-1:0] lineWr;
	logic [wordsPerLine-1:0] lineWe [numWays];
	logic [mdataBits-1:0] metaRd [numWays];
	cacheMeta_u metaWr;
	logic metaWe [numWays];

	logic [numWays-1:0] wayValid;
	logic [numWays-1:0] wayDirty;
	logic [numWays-1:0] wayHit;
	logic hitAny;
	logic freeAny;
	logic [$clog2(numWays)-1:0] hitWay;
	logic [$clog2(numWays)-1:0] freeWay;
	logic [$clog2(numWays)-1:0] victimWay;
	logic [$clog2(numWays)-1:0] targetWay;
	logic [$clog2(numWays)-1:0] wayReg;
	logic [$clog2(numWays)-1:0] rrCount;
	logic [63:0] victimAddr;

	// line engine hookup
	logic rdStart;
	logic rdDone;
	logic [lineBits-1:0] rdLine;
	logic wrStart;
	logic wrDone;
	logic [63:0] wrAddr;
	logic [lineBits-1:0] wrLine;
	logic rdBeatReq;
	logic [63:0] rdBeatAddr;
	logic rdBeatAck;
	logic wrBeatReq;
	logic [63:0] wrBeatAddr;
	logic [beatBits-1:0] wrBeatData;
	logic wrBeatAck;

	enum logic [2:0] {
		idle,
		sramRead,
		lookup,
		respond,
		readMem,
		writeMem,
		flushMem,
		fillDelay
	} state, stateNext;

	assign reqTag = addr[63 -: tagBits];
	assign index = addr[offsetBits +: indexBits];
	assign wordSel = addr[offsetBits-1 -: $clog2(wordsPerLine)];
	assign lineAddr = {reqTag, index, {offsetBits{1'b0}}};

	for (genvar w = 0; w < numWays; w++) begin : gWay
		blockSram #(.wordBits(64), .numWords(wordsPerLine)) dataRam (
			.clk(clk),
			.index(index),
			.rdData(lineRd[w]),
			.wrData(lineWr),
			.wrEnable(lineWe[w])
		);
		blockSram #(.wordBits(mdataBits), .numWords(1)) metaRam (
			.clk(clk),
			.index(index),
			.rdData(metaRd[w]),
			.wrData(metaWr.raw),
			.wrEnable(metaWe[w])
		);
		assign wayDirty[w] = metaRd[w][tagBits+1];
		assign wayValid[w] = metaRd[w][tagBits];
		assign wayHit[w] = wayValid[w] && (metaRd[w][tagBits-1:0] == reqTag);
	end

	// lowest matching way wins in both searches
	always_comb begin
		hitWay = '0;
		freeWay = '0;
		for (int w = numWays - 1; w >= 0; w--) begin
			if (wayHit[w]) begin
				hitWay = w[$clog2(numWays)-1:0];
			end
			if (!wayValid[w]) begin
				freeWay = w[$clog2(numWays)-1:0];
			end
		end
	end

	assign hitAny = |wayHit;
	assign freeAny = !(&wayValid);
	assign victimWay = freeAny ? freeWay : rrCount;
	assign targetWay = hitAny ? hitWay : victimWay;
	// a dirty victim goes back to where it came from
	assign victimAddr = {metaRd[victimWay][tagBits-1:0], index, {offsetBits{1'b0}}};
	assign wrAddr = hitAny ? lineAddr : victimAddr;
	assign wrLine = lineRd[targetWay];
	assign respCyc = state == respond;

	always_comb begin
		stateNext = state;
		rdStart = 1'b0;
		wrStart = 1'b0;
		lineWr = {wordsPerLine{writeData}};
		metaWr.fields.dirty = 1'b0;
		metaWr.fields.valid = 1'b0;
		metaWr.fields.tag = reqTag;
		for (int w = 0; w < numWays; w++) begin
			lineWe[w] = '0;
			metaWe[w] = 1'b0;
		end

		case (state)
			idle: begin
				if (reqCmd != cmdNone) begin
					stateNext = sramRead;
				end
			end
			sramRead: begin
				stateNext = lookup;
			end
			lookup: begin
				if (reqCmd == cmdFlush) begin
					if (hitAny && wayDirty[hitWay]) begin
						wrStart = 1'b1;
						stateNext = flushMem;
					end else begin
						stateNext = respond;
					end
				end else if (hitAny) begin
					if (reqCmd == cmdWrite) begin
						lineWe[hitWay][wordSel] = 1'b1;
						metaWe[hitWay] = 1'b1;
						metaWr.fields.dirty = 1'b1;
						metaWr.fields.valid = 1'b1;
					end
					stateNext = respond;
				end else if (wayValid[victimWay] && wayDirty[victimWay]) begin
					wrStart = 1'b1;
					stateNext = writeMem;
				end else begin
					rdStart = 1'b1;
					stateNext = readMem;
				end
			end
			writeMem: begin
				// victim is out, drop it and fetch the new line
				if (wrDone) begin
					metaWe[wayReg] = 1'b1;
					rdStart = 1'b1;
					stateNext = readMem;
				end
			end
			readMem: begin
				if (rdDone) begin
					lineWr = rdLine;
					lineWe[wayReg] = '1;
					metaWe[wayReg] = 1'b1;
					metaWr.fields.valid = 1'b1;
					stateNext = fillDelay;
				end
			end
			fillDelay: begin
				// lets the RAM read back the filled line
				stateNext = lookup;
			end
			flushMem: begin
				if (wrDone) begin
					metaWe[wayReg] = 1'b1;
					metaWr.fields.valid = 1'b1;
					stateNext = respond;
				end
			end
			respond: begin
				stateNext = idle;
			end
			default: begin
				stateNext = idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			wayReg <= '0;
			rrCount <= '0;
		end else begin
			state <= stateNext;
			if (state == lookup) begin
				wayReg <= targetWay;
			end
			if (state == readMem && rdDone) begin
				rrCount <= rrCount + 1'b1;
			end
		end
	end

	// word 0 sits at the lowest address of the line
	always_ff @(posedge clk) begin
		if (state == lookup) begin
			readData <= lineRd[hitWay][wordSel*64 +: 64];
		end
	end

	lineReader reader (
		.clk(clk),
		.reset(reset),
		.rdStart(rdStart),
		.rdAddr(lineAddr),
		.rdDone(rdDone),
		.rdLine(rdLine),
		.beatReq(rdBeatReq),
		.beatAddr(rdBeatAddr),
		.beatAck(rdBeatAck),
		.beatData(memRData)
	);

	lineWriter writer (
		.clk(clk),
		.reset(reset),
		.wrStart(wrStart),
		.wrAddr(wrAddr),
		.wrLine(wrLine),
		.wrDone(wrDone),
		.beatReq(wrBeatReq),
		.beatAddr(wrBeatAddr),
		.beatWData(wrBeatData),
		.beatAck(wrBeatAck)
	);

	memPortArbiter arbiter (
		.clk(clk),
		.reset(reset),
		.rdReq(rdBeatReq),
		.rdAddr(rdBeatAddr),
		.rdAck(rdBeatAck),
		.wrReq(wrBeatReq),
		.wrAddr(wrBeatAddr),
		.wrData(wrBeatData),
		.wrAck(wrBeatAck),
		.memReq(memReq),
		.memWrite(memWrite),
		.memAddr(memAddr),
		.memWData(memWData),
		.memAck(memAck)
	);

endmodule

/* dv/dCache_assertions.sv */
// ================================================
// protocol checks on the cache top-level ports
// bound into every setAssocDCache instance
// ================================================
`timescale 1ns/1ps

module dCacheAssertions (
	input logic clk,
	input logic reset,
	input logic respCyc,
	input logic memReq,
	input logic memWrite,
	input logic [63:0] memAddr
);

	int failCount = 0;

	// response is a single-cycle pulse
	respPulse: assert property (@(posedge clk) disable iff (reset) respCyc |=> !respCyc)
		else begin
			failCount = failCount + 1;
			$error("respCyc high for two cycles in a row");
		end

	// address and direction hold for the whole burst
	burstStable: assert property (@(posedge clk) disable iff (reset)
		(memReq && $past(memReq)) |-> ($stable(memAddr) && $stable(memWrite)))
		else begin
			failCount = failCount + 1;
			$error("memAddr or memWrite changed while memReq was high");
		end

	resetQuiet: assert property (@(posedge clk) reset |=> (!memReq && !respCyc))
		else begin
			failCount = failCount + 1;
			$error("memReq or respCyc high right after reset");
		end

endmodule

bind setAssocDCache dCacheAssertions protocolChecks (
	.clk(clk),
	.reset(reset),
	.respCyc(respCyc),
	.memReq(memReq),
	.memWrite(memWrite),
	.memAddr(memAddr)
);

/* dv/dCacheTb.sv */
// ================================================
// directed tests for the 4-way data cache
// cache RAMs are taken to start cleared at time zero
// memory model acks each beat after 0 to 2 idle cycles
// ================================================
`timescale 1ns/1ps

module dCacheTb import cachePkg::*, memBusPkg::*; ();

	logic clk = 1'b0;
	logic reset;
	cacheCmd_t reqCmd;
	logic [63:0] addr;
	logic [63:0] writeData;
	logic respCyc;
	logic [63:0] readData;
	logic memReq;
	logic memWrite;
	logic [63:0] memAddr;
	logic [beatBits-1:0] memWData;
	logic memAck = 1'b0;
	logic [beatBits-1:0] memRData = '0;

	// backing store and what the CPU side has written
	logic [63:0] memWords [logic [63:0]];
	logic [63:0] refWords [logic [63:0]];
	int beatNum = 0;
	int gapLeft = 0;
	int readBursts = 0;
	int writeBursts = 0;
	logic burstWrite = 1'b0;
	logic [63:0] lastReadAddr = '0;
	logic [63:0] lastWriteAddr = '0;

	setAssocDCache uut (
		.clk(clk),
		.reset(reset),
		.reqCmd(reqCmd),
		.addr(addr),
		.writeData(writeData),
		.respCyc(respCyc),
		.readData(readData),
		.memReq(memReq),
		.memWrite(memWrite),
		.memAddr(memAddr),
		.memWData(memWData),
		.memAck(memAck),
		.memRData(memRData)
	);

	always #5 clk = ~clk;

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	function automatic string valueError(input string what, input logic [63:0] got,
			input logic [63:0] want);
		return $sformatf("error %0t: %s is %h, expected %h", $time, what, got, want);
	endfunction

	// a word never written holds its own byte address XOR a fixed pattern
	function automatic logic [63:0] freshWord(input logic [63:0] a);
		return a ^ 64'h0000_0000_5a5a_5a5a;
	endfunction

	function automatic logic [63:0] memoryWord(input logic [63:0] a);
		if (memWords.exists(a)) begin
			return memWords[a];
		end
		return freshWord(a);
	endfunction

	function automatic logic [63:0] expectedWord(input logic [63:0] a);
		if (refWords.exists(a)) begin
			return refWords[a];
		end
		return freshWord(a);
	endfunction

	// tag above bit 10, set index in bits 9:6, word in bits 5:3
	function automatic logic [63:0] makeAddr(input int tag, input int idx, input int word);
		return (64'(tag) << 10) | (64'(idx) << 6) | (64'(word) << 3);
	endfunction

	// memory side answers one beat per acked cycle
	always @(negedge clk) begin
		if (reset) begin
			memAck = 1'b0;
			beatNum = 0;
			gapLeft = 0;
		end else begin
			// ack from the last falling edge was taken at the rising edge
			if (memAck) begin
				beatNum++;
				if (beatNum == beatsPerBurst) begin
					if (burstWrite) begin
						writeBursts++;
					end else begin
						readBursts++;
					end
				end
			end
			memAck = 1'b0;
			if (!memReq) begin
				assert (beatNum == 0 || beatNum == beatsPerBurst)
					else abortRun("memory request dropped in the middle of a burst");
				beatNum = 0;
			end else if (beatNum < beatsPerBurst) begin
				if (gapLeft > 0) begin
					gapLeft--;
				end else begin
					if (beatNum == 0) begin
						assert (memAddr[5:0] == 6'd0)
							else abortRun("memory burst address is not line aligned");
						burstWrite = memWrite;
						if (memWrite) begin
							lastWriteAddr = memAddr;
						end else begin
							lastReadAddr = memAddr;
						end
					end
					memAck = 1'b1;
					if (memWrite) begin
						memWords[memAddr + 64'(beatNum * 8)] = memWData;
					end else begin
						memRData = memoryWord(memAddr + 64'(beatNum * 8));
					end
					gapLeft = $urandom_range(2, 0);
				end
			end
		end
	end

	// holds the command until respCyc and counts falling edges in cycles
	task automatic runCmd(input cacheCmd_t cmd, input logic [63:0] a, input logic [63:0] wd,
			output logic [63:0] rd, output int cycles);
		cycles = 0;
		@(negedge clk);
		reqCmd = cmd;
		addr = a;
		writeData = wd;
		do begin
			@(negedge clk);
			cycles++;
			assert (cycles <= 400)
				else abortRun($sformatf("no response to a %s command at %h", cmd.name(), a));
		end while (!respCyc);
		rd = readData;
		reqCmd = cmdNone;
		if (cmd == cmdWrite) begin
			refWords[a] = wd;
		end
	endtask

	task automatic readMiss();
		logic [63:0] a;
		logic [63:0] rd;
		int cycles;
		int rdBefore;
		int wrBefore;
		a = makeAddr(7, 3, 2);
		rdBefore = readBursts;
		wrBefore = writeBursts;
		runCmd(cmdRead, a, 64'd0, rd, cycles);
		assert (rd == freshWord(a)) else abortRun(valueError("read miss data", rd, freshWord(a)));
		assert (readBursts == rdBefore + 1 && writeBursts == wrBefore)
			else abortRun("read miss did not make exactly one read burst");
		assert (lastReadAddr == makeAddr(7, 3, 0))
			else abortRun(valueError("fill address", lastReadAddr, makeAddr(7, 3, 0)));
	endtask

	task automatic writeReadHit();
		logic [63:0] a;
		logic [63:0] data;
		logic [63:0] rd;
		int cycles;
		int bursts;
		// same line as the read miss, so both commands hit
		a = makeAddr(7, 3, 5);
		data = {$urandom, $urandom};
		bursts = readBursts + writeBursts;
		runCmd(cmdWrite, a, data, rd, cycles);
		assert (cycles == 3) else abortRun(valueError("write hit latency", 64'(cycles), 64'd3));
		runCmd(cmdRead, a, 64'd0, rd, cycles);
		assert (cycles == 3) else abortRun(valueError("read hit latency", 64'(cycles), 64'd3));
		assert (rd == data) else abortRun(valueError("read hit data", rd, data));
		assert (readBursts + writeBursts == bursts) else abortRun("a hit used the memory port");
	endtask

	task automatic evictWriteBack();
		logic [63:0] rd;
		logic [63:0] victimAddr;
		int cycles;
		int victimTag;
		int wrBefore;
		// free ways fill lowest first, so way k takes tag 20 + k
		for (int t = 0; t < 4; t++) begin
			runCmd(cmdWrite, makeAddr(20 + t, 5, 1), {$urandom, $urandom}, rd, cycles);
		end
		// round robin advances on every fill, and every read burst is a fill
		victimTag = 20 + readBursts % numWays;
		victimAddr = makeAddr(victimTag, 5, 1);
		wrBefore = writeBursts;
		runCmd(cmdWrite, makeAddr(24, 5, 1), {$urandom, $urandom}, rd, cycles);
		assert (writeBursts == wrBefore + 1) else abortRun("fifth tag did not write back a victim");
		assert (lastWriteAddr == makeAddr(victimTag, 5, 0))
			else abortRun(valueError("write-back address", lastWriteAddr,
				makeAddr(victimTag, 5, 0)));
		assert (memWords.exists(victimAddr) && memWords[victimAddr] == expectedWord(victimAddr))
			else abortRun(valueError("written-back word", memoryWord(victimAddr),
				expectedWord(victimAddr)));
		runCmd(cmdRead, victimAddr, 64'd0, rd, cycles);
		assert (rd == expectedWord(victimAddr))
			else abortRun(valueError("evicted word read", rd, expectedWord(victimAddr)));
	endtask

	task automatic flushLine();
		logic [63:0] a;
		logic [63:0] wa;
		logic [63:0] rd;
		int cycles;
		int rdBefore;
		int wrBefore;
		a = makeAddr(40, 9, 6);
		runCmd(cmdWrite, a, {$urandom, $urandom}, rd, cycles);
		rdBefore = readBursts;
		wrBefore = writeBursts;
		runCmd(cmdFlush, a, 64'd0, rd, cycles);
		assert (writeBursts == wrBefore + 1 && readBursts == rdBefore)
			else abortRun("flush of a dirty line did not make one write burst");
		assert (lastWriteAddr == makeAddr(40, 9, 0))
			else abortRun(valueError("flush address", lastWriteAddr, makeAddr(40, 9, 0)));
		for (int w = 0; w < wordsPerLine; w++) begin
			wa = makeAddr(40, 9, w);
			assert (memWords.exists(wa) && memWords[wa] == expectedWord(wa))
				else abortRun(valueError("flushed word", memoryWord(wa), expectedWord(wa)));
		end
		// line is clean now
		runCmd(cmdFlush, a, 64'd0, rd, cycles);
		assert (writeBursts == wrBefore + 1 && readBursts == rdBefore)
			else abortRun("second flush used the memory port");
	endtask

	task automatic randomMix();
		logic [63:0] a;
		logic [63:0] data;
		logic [63:0] want;
		logic [63:0] rd;
		int cycles;
		int idx;
		int tag;
		// six tags over sets 3, 7 and 11 overflow the four ways
		for (int n = 0; n < 150; n++) begin
			idx = 3 + 4 * int'($urandom_range(2, 0));
			tag = 60 + int'($urandom_range(5, 0));
			a = makeAddr(tag, idx, int'($urandom_range(7, 0)));
			if ($urandom_range(1, 0) == 1) begin
				data = {$urandom, $urandom};
				runCmd(cmdWrite, a, data, rd, cycles);
			end else begin
				want = expectedWord(a);
				runCmd(cmdRead, a, 64'd0, rd, cycles);
				assert (rd == want) else abortRun(valueError("random read", rd, want));
			end
		end
	endtask

	initial begin
		void'($urandom(32'hc922_cad1));
		reset = 1'b1;
		reqCmd = cmdNone;
		addr = '0;
		writeData = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		readMiss();
		writeReadHit();
		evictWriteBack();
		flushLine();
		randomMix();

		if (uut.protocolChecks.failCount == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			abortRun("bound protocol assertions failed during the run");
		end
	end

endmodule

/* setAssocDCache.f */
design/cachePkg.sv
design/memBusPkg.sv
design/blockSram.sv
design/lineReader.sv
design/lineWriter.sv
design/memPortArbiter.sv
design/setAssocDCache.sv
dv/dCache_assertions.sv
dv/dCacheTb.sv

/* run.sh */
#!/bin/sh
# builds and runs the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Mdir obj_dir --top-module dCacheTb -f setAssocDCache.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/VdCacheTb > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Checks failed" "$log"; then
	echo "simulation reported a failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if ! grep -q "All checks passed" "$log"; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0
